/* files.f */
hdl/soc_bus_pkg.sv
hdl/uart_pkg.sv
hdl/dbus.sv
hdl/data_ram.sv
hdl/gpio_regs.sv
hdl/uart_tx_fifo.sv
hdl/uart_tx.sv
hdl/uart_top.sv
hdl/soc_toplevel.sv
tests/soc_checker.sv
tests/soc_tb.sv

/* hdl/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic                           clk_i,
    input  logic                           req_i,
    input  logic                           we_i,
    input  logic [soc_bus_pkg::OFS_W-1:0]  adr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0] dat_i,
    input  logic [soc_bus_pkg::SEL_W-1:0]  sel_i,
    output logic [soc_bus_pkg::DATA_W-1:0] dat_o
);

    localparam int AW = $clog2(soc_bus_pkg::RAM_WORDS);

    logic [soc_bus_pkg::DATA_W-1:0] mem [soc_bus_pkg::RAM_WORDS];
    logic [AW-1:0]                  word_idx;

    // Byte address to word index.
    assign word_idx = adr_i[AW+1:2];

    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int b = 0; b < soc_bus_pkg::SEL_W; b++) begin
                if (sel_i[b]) begin
                    mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
    end

    // Registered read.
    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            dat_o <= mem[word_idx];
        end
    end

endmodule

/* hdl/dbus.sv */
`timescale 1ns/1ps

module dbus (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0] wb_dat_i,
    input  logic [soc_bus_pkg::SEL_W-1:0]  wb_sel_i,
    output logic [soc_bus_pkg::DATA_W-1:0] wb_dat_o,
    output logic                           wb_ack_o,
    output logic                           ram_req_o,
    output logic                           uart_req_o,
    output logic                           gpio_req_o,
    output logic                           slv_we_o,
    output logic [soc_bus_pkg::OFS_W-1:0]  slv_adr_o,
    output logic [soc_bus_pkg::DATA_W-1:0] slv_dat_o,
    output logic [soc_bus_pkg::SEL_W-1:0]  slv_sel_o,
    input  logic [soc_bus_pkg::DATA_W-1:0] ram_dat_i,
    input  logic [soc_bus_pkg::DATA_W-1:0] uart_dat_i,
    input  logic [soc_bus_pkg::DATA_W-1:0] gpio_dat_i,
    input  logic                           uart_ready_i
);

    soc_bus_pkg::slave_e dec_slv;
    soc_bus_pkg::slave_e slv_q;
    logic                busy_q;
    logic                ack_q;
    logic                issue;

    // ****************************************
    // Address decode and request strobes.
    // ****************************************
    always_comb begin
        case (wb_adr_i[13:12])
            soc_bus_pkg::RAM_BASE[13:12]:  dec_slv = soc_bus_pkg::SLV_RAM;
            soc_bus_pkg::UART_BASE[13:12]: dec_slv = soc_bus_pkg::SLV_UART;
            soc_bus_pkg::GPIO_BASE[13:12]: dec_slv = soc_bus_pkg::SLV_GPIO;
            default:                       dec_slv = soc_bus_pkg::SLV_NONE;
        endcase
    end

    // Only the UART can stall a transfer.
    assign issue = wb_cyc_i && wb_stb_i && !busy_q &&
                   (dec_slv != soc_bus_pkg::SLV_UART || uart_ready_i);

    assign ram_req_o  = issue && (dec_slv == soc_bus_pkg::SLV_RAM);
    assign uart_req_o = issue && (dec_slv == soc_bus_pkg::SLV_UART);
    assign gpio_req_o = issue && (dec_slv == soc_bus_pkg::SLV_GPIO);

    assign slv_we_o  = wb_we_i;
    assign slv_adr_o = wb_adr_i[soc_bus_pkg::OFS_W-1:0];
    assign slv_dat_o = wb_dat_i;
    assign slv_sel_o = wb_sel_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q  <= 1'b0;
            busy_q <= 1'b0;
            slv_q  <= soc_bus_pkg::SLV_NONE;
        end else begin
            ack_q <= issue;
            if (issue) begin
                busy_q <= 1'b1;
                slv_q  <= dec_slv;
            end else if (!wb_stb_i || !wb_cyc_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // ****************************************
    // Read data return.
    // ****************************************
    always_comb begin
        case (slv_q)
            soc_bus_pkg::SLV_RAM:  wb_dat_o = ram_dat_i;
            soc_bus_pkg::SLV_UART: wb_dat_o = uart_dat_i;
            soc_bus_pkg::SLV_GPIO: wb_dat_o = gpio_dat_i;
            default:               wb_dat_o = '0;
        endcase
    end

    assign wb_ack_o = ack_q;

endmodule

/* hdl/gpio_regs.sv */
`timescale 1ns/1ps

module gpio_regs (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           req_i,
    input  logic                           we_i,
    input  logic [soc_bus_pkg::OFS_W-1:0]  adr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0] dat_i,
    input  logic [soc_bus_pkg::SEL_W-1:0]  sel_i,
    input  logic [soc_bus_pkg::DATA_W-1:0] gpio_i,
    output logic [soc_bus_pkg::DATA_W-1:0] dat_o,
    output logic [soc_bus_pkg::DATA_W-1:0] gpio_o
);

    logic [soc_bus_pkg::DATA_W-1:0] out_q;
    logic [soc_bus_pkg::DATA_W-1:0] sync1_q;
    logic [soc_bus_pkg::DATA_W-1:0] sync2_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q   <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            // Two flop synchronizer on the inputs.
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            if (req_i && we_i && adr_i == soc_bus_pkg::GPIO_OUT_OFS) begin
                for (int b = 0; b < soc_bus_pkg::SEL_W; b++) begin
                    if (sel_i[b]) begin
                        out_q[8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            if (adr_i == soc_bus_pkg::GPIO_OUT_OFS) begin
                dat_o <= out_q;
            end else if (adr_i == soc_bus_pkg::GPIO_IN_OFS) begin
                dat_o <= sync2_q;
            end else begin
                dat_o <= '0;
            end
        end
    end

    assign gpio_o = out_q;

endmodule

/* hdl/soc_bus_pkg.sv */
package soc_bus_pkg;

    // Bus widths.
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    // Offset within a slave window.
    localparam int OFS_W = 12;

    localparam int RAM_WORDS = 256;

    // Address map decoded on bits 13 and 12.
    localparam logic [ADDR_W-1:0] RAM_BASE  = 16'h0000;
    localparam logic [ADDR_W-1:0] UART_BASE = 16'h1000;
    localparam logic [ADDR_W-1:0] GPIO_BASE = 16'h2000;

    // GPIO register offsets.
    localparam logic [OFS_W-1:0] GPIO_OUT_OFS = 12'h000;
    localparam logic [OFS_W-1:0] GPIO_IN_OFS  = 12'h004;

    typedef enum logic [1:0] {
        SLV_RAM  = 2'b00,
        SLV_UART = 2'b01,
        SLV_GPIO = 2'b10,
        SLV_NONE = 2'b11
    } slave_e;

endpackage

/* hdl/soc_toplevel.sv */
`timescale 1ns/1ps

module soc_toplevel (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0] wb_dat_i,
    input  logic [soc_bus_pkg::SEL_W-1:0]  wb_sel_i,
    output logic [soc_bus_pkg::DATA_W-1:0] wb_dat_o,
    output logic                           wb_ack_o,
    input  logic [soc_bus_pkg::DATA_W-1:0] gpio_i,
    output logic [soc_bus_pkg::DATA_W-1:0] gpio_o,
    output logic                           txd_o,
    output logic                           uart_irq_o
);

    logic                           ram_req;
    logic                           uart_req;
    logic                           gpio_req;
    logic                           slv_we;
    logic [soc_bus_pkg::OFS_W-1:0]  slv_adr;
    logic [soc_bus_pkg::DATA_W-1:0] slv_dat;
    logic [soc_bus_pkg::SEL_W-1:0]  slv_sel;
    logic [soc_bus_pkg::DATA_W-1:0] ram_dat;
    logic [soc_bus_pkg::DATA_W-1:0] uart_dat;
    logic [soc_bus_pkg::DATA_W-1:0] gpio_dat;
    logic                           uart_ready;

    // ****************************************
    // Data bus decoder.
    // ****************************************
    dbus dbus0 (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .ram_req_o    (ram_req),
        .uart_req_o   (uart_req),
        .gpio_req_o   (gpio_req),
        .slv_we_o     (slv_we),
        .slv_adr_o    (slv_adr),
        .slv_dat_o    (slv_dat),
        .slv_sel_o    (slv_sel),
        .ram_dat_i    (ram_dat),
        .uart_dat_i   (uart_dat),
        .gpio_dat_i   (gpio_dat),
        .uart_ready_i (uart_ready)
    );

    // ****************************************
    // Slaves.
    // ****************************************
    data_ram ram0 (
        .clk_i (clk_i),
        .req_i (ram_req),
        .we_i  (slv_we),
        .adr_i (slv_adr),
        .dat_i (slv_dat),
        .sel_i (slv_sel),
        .dat_o (ram_dat)
    );

    gpio_regs gpio0 (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (gpio_req),
        .we_i     (slv_we),
        .adr_i    (slv_adr),
        .dat_i    (slv_dat),
        .sel_i    (slv_sel),
        .gpio_i   (gpio_i),
        .dat_o    (gpio_dat),
        .gpio_o   (gpio_o)
    );

    uart_top uart0 (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .req_i      (uart_req),
        .we_i       (slv_we),
        .adr_i      (slv_adr),
        .dat_i      (slv_dat),
        .dat_o      (uart_dat),
        .ready_o    (uart_ready),
        .txd_o      (txd_o),
        .uart_irq_o (uart_irq_o)
    );

endmodule

/* hdl/uart_pkg.sv */
package uart_pkg;

    // Register offsets.
    localparam logic [11:0] UART_DATA_OFS = 12'h000;
    localparam logic [11:0] UART_STAT_OFS = 12'h004;

    // Serial bit time in bus clocks.
    localparam int CLKS_PER_BIT = 8;

    localparam int FIFO_DEPTH = 4;

    // Transmitter states.
    typedef enum logic [1:0] {
        TX_IDLE  = 2'b00,
        TX_START = 2'b01,
        TX_DATA  = 2'b10,
        TX_STOP  = 2'b11
    } tx_state_e;

endpackage

/* hdl/uart_top.sv */
`timescale 1ns/1ps

module uart_top (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           req_i,
    input  logic                           we_i,
    input  logic [soc_bus_pkg::OFS_W-1:0]  adr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0] dat_i,
    output logic [soc_bus_pkg::DATA_W-1:0] dat_o,
    output logic                           ready_o,
    output logic                           txd_o,
    output logic                           uart_irq_o
);

    logic       data_sel;
    logic       push;
    logic       pop;
    logic       full;
    logic       empty;
    logic       tx_busy;
    logic       idle;
    logic [7:0] fifo_dat;

    assign data_sel = (adr_i == uart_pkg::UART_DATA_OFS);

    // Hold off data writes while the FIFO is full.
    assign ready_o = !(we_i && data_sel && full);
    assign push    = req_i && we_i && data_sel;

    assign idle       = empty && !tx_busy;
    assign uart_irq_o = idle;

    // Only the status register reads nonzero.
    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            if (adr_i == uart_pkg::UART_STAT_OFS) begin
                dat_o <= {{(soc_bus_pkg::DATA_W-2){1'b0}}, full, idle};
            end else begin
                dat_o <= '0;
            end
        end
    end

    uart_tx_fifo fifo0 (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .push_i     (push),
        .push_dat_i (dat_i[7:0]),
        .pop_i      (pop),
        .pop_dat_o  (fifo_dat),
        .full_o     (full),
        .empty_o    (empty)
    );

    uart_tx tx0 (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .empty_i  (empty),
        .dat_i    (fifo_dat),
        .pop_o    (pop),
        .busy_o   (tx_busy),
        .txd_o    (txd_o)
    );

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       empty_i,
    input  logic [7:0] dat_i,
    output logic       pop_o,
    output logic       busy_o,
    output logic       txd_o
);

    localparam int CNT_W = $clog2(uart_pkg::CLKS_PER_BIT);

    uart_pkg::tx_state_e state_q;
    logic [CNT_W-1:0]    cnt_q;
    logic [2:0]          bit_q;
    logic [7:0]          shift_q;
    logic                bit_end;

    assign bit_end = (cnt_q == CNT_W'(uart_pkg::CLKS_PER_BIT - 1));

    // Byte is taken in the first cycle of the start bit.
    assign pop_o  = (state_q == uart_pkg::TX_START) && (cnt_q == '0);
    assign busy_o = (state_q != uart_pkg::TX_IDLE);

    // ****************************************
    // Frame sequencer.
    // ****************************************
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= uart_pkg::TX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
        end else begin
            if (state_q == uart_pkg::TX_IDLE || bit_end) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            case (state_q)
                uart_pkg::TX_IDLE: begin
                    if (!empty_i) begin
                        state_q <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        state_q <= uart_pkg::TX_DATA;
                        bit_q   <= '0;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= uart_pkg::TX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state_q <= uart_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB first.
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            shift_q <= dat_i;
        end else if (state_q == uart_pkg::TX_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_comb begin
        case (state_q)
            uart_pkg::TX_START: txd_o = 1'b0;
            uart_pkg::TX_DATA:  txd_o = shift_q[0];
            default:            txd_o = 1'b1;
        endcase
    end

endmodule

/* hdl/uart_tx_fifo.sv */
`timescale 1ns/1ps

module uart_tx_fifo (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       push_i,
    input  logic [7:0] push_dat_i,
    input  logic       pop_i,
    output logic [7:0] pop_dat_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int PTR_W = $clog2(uart_pkg::FIFO_DEPTH);

    logic [7:0]       mem [uart_pkg::FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push_ok;
    logic             pop_ok;

    assign full_o  = (count_q == (PTR_W+1)'(uart_pkg::FIFO_DEPTH));
    assign empty_o = (count_q == '0);

    // Requests against the wrong flag are ignored.
    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem[wr_ptr_q] <= push_dat_i;
        end
    end

    assign pop_dat_o = mem[rd_ptr_q];

endmodule

/* tests/soc_checker.sv */
`timescale 1ns/1ps

module soc_checker (
    input logic                           clk_i,
    input logic                           arst_n_i,
    input logic                           wb_cyc_i,
    input logic                           wb_stb_i,
    input logic                           wb_we_i,
    input logic [soc_bus_pkg::ADDR_W-1:0] wb_adr_i,
    input logic [soc_bus_pkg::DATA_W-1:0] wb_dat_i,
    input logic [soc_bus_pkg::SEL_W-1:0]  wb_sel_i,
    input logic [soc_bus_pkg::DATA_W-1:0] wb_dat_o,
    input logic                           wb_ack_o,
    input logic [soc_bus_pkg::DATA_W-1:0] gpio_i,
    input logic [soc_bus_pkg::DATA_W-1:0] gpio_o,
    input logic                           txd_o,
    input logic                           uart_irq_o,
    input logic                           uart_req,
    input logic                           slv_we,
    input logic [soc_bus_pkg::OFS_W-1:0]  slv_adr
);

    int fail_cnt = 0;

    logic [soc_bus_pkg::DATA_W-1:0] ram_sh [soc_bus_pkg::RAM_WORDS];
    logic [soc_bus_pkg::DATA_W-1:0] gpio_sh;
    logic [soc_bus_pkg::DATA_W-1:0] gpio_d1;
    logic [soc_bus_pkg::DATA_W-1:0] gpio_d2;
    logic [soc_bus_pkg::DATA_W-1:0] gpio_d3;
    logic [7:0]                     exp_mem [64];
    logic [5:0]                     wr_idx;
    logic [5:0]                     rd_idx;
    logic [3:0]                     occ;
    logic                           txd_q;
    logic                           rx_busy;
    logic [6:0]                     rx_cnt;
    logic [7:0]                     rx_shift;
    logic                           rx_start;
    logic                           smp;
    logic [3:0]                     bit_k;
    logic                           is_ram;
    logic                           is_uart;
    logic                           is_gpio;
    logic                           is_none;
    logic                           uart_dw;
    logic                           wr_ack;
    logic                           rd_ack;

    assign is_ram  = wb_adr_i[13:12] == soc_bus_pkg::RAM_BASE[13:12];
    assign is_uart = wb_adr_i[13:12] == soc_bus_pkg::UART_BASE[13:12];
    assign is_gpio = wb_adr_i[13:12] == soc_bus_pkg::GPIO_BASE[13:12];
    assign is_none = !is_ram && !is_uart && !is_gpio;
    assign uart_dw = is_uart && wb_we_i && wb_adr_i[11:0] == uart_pkg::UART_DATA_OFS;
    assign wr_ack  = wb_ack_o && wb_we_i;
    assign rd_ack  = wb_ack_o && !wb_we_i;

    // ****************************************
    // Shadow models.
    // ****************************************
    always_ff @(posedge clk_i) begin
        if (wr_ack && is_ram) begin
            for (int b = 0; b < soc_bus_pkg::SEL_W; b++) begin
                if (wb_sel_i[b]) begin
                    ram_sh[wb_adr_i[9:2]][8*b +: 8] <= wb_dat_i[8*b +: 8];
                end
            end
        end
    end

    // GPIO input as it was three cycles ago.
    always_ff @(posedge clk_i) begin
        gpio_d1 <= gpio_i;
        gpio_d2 <= gpio_d1;
        gpio_d3 <= gpio_d2;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gpio_sh <= '0;
            wr_idx  <= '0;
        end else begin
            if (wr_ack && is_gpio && wb_adr_i[11:0] == soc_bus_pkg::GPIO_OUT_OFS) begin
                for (int b = 0; b < soc_bus_pkg::SEL_W; b++) begin
                    if (wb_sel_i[b]) begin
                        gpio_sh[8*b +: 8] <= wb_dat_i[8*b +: 8];
                    end
                end
            end
            if (wr_ack && uart_dw) begin
                exp_mem[wr_idx] <= wb_dat_i[7:0];
                wr_idx          <= wr_idx + 1'b1;
            end
        end
    end

    // ****************************************
    // Serial receiver with mid-bit sampling.
    // ****************************************
    assign rx_start = !rx_busy && txd_q && !txd_o;
    assign smp      = rx_busy && rx_cnt[2:0] == 3'd4;
    assign bit_k    = rx_cnt[6:3];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            txd_q   <= 1'b1;
            rx_busy <= 1'b0;
            rx_cnt  <= '0;
            rd_idx  <= '0;
            occ     <= '0;
        end else begin
            txd_q <= txd_o;
            // A frame start marks the FIFO pop.
            occ <= occ + 4'(uart_req && slv_we && slv_adr == uart_pkg::UART_DATA_OFS)
                       - 4'(rx_start);
            if (rx_start) begin
                rx_busy <= 1'b1;
                rx_cnt  <= 7'd1;
            end else if (rx_busy) begin
                rx_cnt <= rx_cnt + 1'b1;
                if (smp && bit_k >= 4'd1 && bit_k <= 4'd8) begin
                    rx_shift <= {txd_o, rx_shift[7:1]};
                end
                if (smp && bit_k == 4'd9) begin
                    rx_busy <= 1'b0;
                    rd_idx  <= rd_idx + 1'b1;
                end
            end
        end
    end

    // ****************************************
    // Assertions.
    // ****************************************
    a_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> !wb_ack_o && txd_o && gpio_o == '0 && uart_irq_o)
        else begin fail_cnt++; $error("values after reset are wrong"); end

    a_ack_stb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_ack_o |-> wb_cyc_i && wb_stb_i)
        else begin fail_cnt++; $error("ack seen without cyc and stb"); end

    a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (wb_cyc_i && wb_stb_i && !$past(wb_stb_i) && !uart_dw) |-> !wb_ack_o ##1 wb_ack_o)
        else begin fail_cnt++; $error("ack not two edges after the request"); end

    a_ram_rd: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_ack && is_ram) |-> wb_dat_o == ram_sh[wb_adr_i[9:2]])
        else begin
            fail_cnt++;
            $error("[ERROR] wb_dat_o 0x%h, expected 0x%h", wb_dat_o, ram_sh[wb_adr_i[9:2]]);
        end

    a_gpio_rd: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_ack && is_gpio && wb_adr_i[11:0] == soc_bus_pkg::GPIO_OUT_OFS)
        |-> wb_dat_o == gpio_sh)
        else begin fail_cnt++; $error("[ERROR] wb_dat_o 0x%h, expected 0x%h", wb_dat_o, gpio_sh); end

    a_gpio_o: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !wb_ack_o |-> gpio_o == gpio_sh)
        else begin fail_cnt++; $error("[ERROR] gpio_o 0x%h, expected 0x%h", gpio_o, gpio_sh); end

    a_gpio_in: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_ack && is_gpio && wb_adr_i[11:0] == soc_bus_pkg::GPIO_IN_OFS)
        |-> wb_dat_o == gpio_d3)
        else begin fail_cnt++; $error("[ERROR] wb_dat_o 0x%h, expected 0x%h", wb_dat_o, gpio_d3); end

    a_unmapped: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_ack && (is_none || (is_gpio && wb_adr_i[11:0] != soc_bus_pkg::GPIO_OUT_OFS
                                 && wb_adr_i[11:0] != soc_bus_pkg::GPIO_IN_OFS)))
        |-> wb_dat_o == '0)
        else begin fail_cnt++; $error("[ERROR] wb_dat_o 0x%h, expected 0x0", wb_dat_o); end

    a_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_ack && is_uart && wb_adr_i[11:0] == uart_pkg::UART_STAT_OFS)
        |-> wb_dat_o[1] == $past(occ == 4'(uart_pkg::FIFO_DEPTH)))
        else begin
            fail_cnt++;
            $error("[ERROR] wb_dat_o[1] 0x%h, expected 0x%h", wb_dat_o[1], !wb_dat_o[1]);
        end

    a_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (smp && bit_k == 4'd0) |-> !txd_o)
        else begin fail_cnt++; $error("start bit is not low"); end

    a_stop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (smp && bit_k == 4'd9) |-> txd_o)
        else begin fail_cnt++; $error("stop bit is not high"); end

    a_byte: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (smp && bit_k == 4'd9) |-> rd_idx != wr_idx && rx_shift == exp_mem[rd_idx])
        else begin
            fail_cnt++;
            $error("[ERROR] txd_o byte 0x%h, expected 0x%h", rx_shift, exp_mem[rd_idx]);
        end

    a_irq: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (smp && bit_k == 4'd9 && occ == '0) |-> ##[0:uart_pkg::CLKS_PER_BIT] uart_irq_o)
        else begin fail_cnt++; $error("uart_irq_o did not return after the last frame"); end

endmodule

/* tests/soc_tb.sv */
`timescale 1ns/1ps

module soc_tb;

    localparam int N_XFER  = 45;
    localparam int N_BYTES = 9;
    localparam int WATCHDOG_NS =
        (N_XFER * 4 + N_BYTES * 10 * uart_pkg::CLKS_PER_BIT + 200) * 20;

    logic                           clk_i;
    logic                           arst_n_i;
    logic                           wb_cyc_i;
    logic                           wb_stb_i;
    logic                           wb_we_i;
    logic [soc_bus_pkg::ADDR_W-1:0] wb_adr_i;
    logic [soc_bus_pkg::DATA_W-1:0] wb_dat_i;
    logic [soc_bus_pkg::SEL_W-1:0]  wb_sel_i;
    logic [soc_bus_pkg::DATA_W-1:0] wb_dat_o;
    logic                           wb_ack_o;
    logic [soc_bus_pkg::DATA_W-1:0] gpio_i;
    logic [soc_bus_pkg::DATA_W-1:0] gpio_o;
    logic                           txd_o;
    logic                           uart_irq_o;

    logic [31:0]                    rng;
    logic [31:0]                    rdata;
    logic [soc_bus_pkg::ADDR_W-1:0] ram_adr [8];

    soc_toplevel dut_i (.*);

    bind soc_toplevel soc_checker chk0 (.*);

    initial begin
        clk_i = 1'b0;
    end

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One Wishbone classic transfer that returns the read data of the ack cycle.
    task automatic bus_xfer(input logic we, input logic [15:0] adr,
                            input logic [31:0] dat, input logic [3:0] sel,
                            output logic [31:0] rd);
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        wb_sel_i <= sel;
        do begin
            @(posedge clk_i);
        end while (!wb_ack_o);
        rd = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic wait_uart_idle();
        repeat (2) @(posedge clk_i);
        while (!uart_irq_o) begin
            @(posedge clk_i);
        end
        repeat (10) @(posedge clk_i);
    endtask

    // ****************************************
    // Watchdog and failure monitor.
    // ****************************************
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run timed out");
        $display("tests failed");
        $fatal(1, "timeout");
    end

    always @(posedge clk_i) begin
        if (dut_i.chk0.fail_cnt != 0) begin
            $display("tests failed");
            $fatal(1, "assertion failure");
        end
    end

    // ****************************************
    // Stimulus.
    // ****************************************
    initial begin
        arst_n_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        rng      = 32'd97727;
        rng      = xorshift(rng);
        gpio_i   = rng;
        repeat (16) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // RAM full writes, then merged partial writes, then readback.
        for (int i = 0; i < 8; i++) begin
            rng = xorshift(rng);
            ram_adr[i] = {6'h00, rng[7:0], 2'b00};
            rng = xorshift(rng);
            bus_xfer(1'b1, ram_adr[i], rng, 4'hf, rdata);
        end
        for (int i = 0; i < 8; i++) begin
            rng = xorshift(rng);
            bus_xfer(1'b1, ram_adr[rng[2:0]], xorshift(rng), rng[11:8], rdata);
        end
        for (int i = 0; i < 8; i++) begin
            bus_xfer(1'b0, ram_adr[i], '0, 4'hf, rdata);
        end

        // GPIO output, input and unmapped reads.
        rng = xorshift(rng);
        gpio_i <= rng;
        for (int i = 0; i < 3; i++) begin
            rng = xorshift(rng);
            bus_xfer(1'b1, 16'h2000, rng, rng[7:4], rdata);
            bus_xfer(1'b0, 16'h2000, '0, 4'hf, rdata);
        end
        bus_xfer(1'b0, 16'h2004, '0, 4'hf, rdata);
        bus_xfer(1'b0, 16'h2008, '0, 4'hf, rdata);
        bus_xfer(1'b0, 16'h3000, '0, 4'hf, rdata);
        bus_xfer(1'b0, 16'h3ffc, '0, 4'hf, rdata);

        // UART single frames.
        bus_xfer(1'b0, 16'h1004, '0, 4'hf, rdata);
        for (int i = 0; i < 3; i++) begin
            rng = xorshift(rng);
            bus_xfer(1'b1, 16'h1000, rng, 4'hf, rdata);
        end
        wait_uart_idle();

        // The last back-pressure writes stall on a full FIFO.
        for (int i = 0; i < 6; i++) begin
            rng = xorshift(rng);
            bus_xfer(1'b1, 16'h1000, rng, 4'hf, rdata);
        end
        bus_xfer(1'b0, 16'h1004, '0, 4'hf, rdata);
        wait_uart_idle();

        if (dut_i.chk0.fail_cnt == 0 && dut_i.chk0.rd_idx == dut_i.chk0.wr_idx) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("not every byte written to the UART came out on txd_o");
            $display("tests failed");
            $fatal(1, "end of run check");
        end
    end

endmodule
